//--- mulPkg.sv
// Multiplier shared definitions
package mulPkg;

	////////////////////
	// Widths
	////////////////////

	// Operand widths, fixed for the packed types below
	localparam int opWidthX = 8;
	localparam int opWidthY = 8;
	// Full product needs both widths
	localparam int prodWidth = opWidthX + opWidthY;

	////////////////////
	// Vector types
	////////////////////

	typedef logic [opWidthX-1:0] opX_t;
	typedef logic [opWidthY-1:0] opY_t;
	typedef logic [prodWidth-1:0] prod_t;

	// One row per multiplier bit, each row product wide
	typedef logic [opWidthX*prodWidth-1:0] ppArray_t;

	// Pass counter, large enough for one row per pass
	typedef logic [2:0] passIdx_t;

	// Redundant carry-save pair
	typedef struct packed {
		prod_t sum;
		prod_t carry;
	} csPair_t;

	// Final adder architecture
	typedef enum logic [1:0] {
		SLOW = 2'b00,    // ripple
		MEDIUM = 2'b01,  // Sklansky
		FAST = 2'b10     // Kogge-Stone
	} speed_e;

	// Floor of log2, n > 0 expected
	function automatic int log2floor(input int n);
		int m;
		int p;
		m = -1;
		p = 1;
		while (p <= n) begin
			m = m + 1;
			p = p * 2;
		end
		return m;
	endfunction

endpackage

//--- MulPPGenUns.sv
// Braun partial-product generator
`timescale 1ns/1ps

module MulPPGenUns #(
	parameter int widthX = 8,  // multiplier width
	parameter int widthY = 8   // multiplicand width
) (
	input  mulPkg::opX_t     X,
	input  mulPkg::opY_t     Y,
	output mulPkg::ppArray_t PP
);
	import mulPkg::*;

	// Row width equals full product width
	localparam int widthP = widthX + widthY;

	// Widths must agree with the packed array type
	if (widthX != opWidthX || widthY != opWidthY) begin : genWidthCheck
		$error("MulPPGenUns widths differ from package operand widths");
	end

	////////////////////
	// Row generation
	////////////////////

	always_comb begin : ppGen
		// Zeros outside the shifted band
		PP = '0;
		// Row i holds x(i)y(k) at column i+k
		for (int i = 0; i < widthX; i++) begin
			for (int k = 0; k < widthY; k++) begin
				PP[i*widthP+i+k] = X[i] & Y[k];
			end
		end
	end

endmodule

//--- CsaAccumulator.sv
// Carry-save row accumulator
`timescale 1ns/1ps

module CsaAccumulator #(
	parameter int rowsPerCycle = 2
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             clear,
	input  logic             accumulate,
	input  mulPkg::passIdx_t pass,
	input  mulPkg::ppArray_t pp,
	output mulPkg::csPair_t  acc
);
	import mulPkg::*;

	// Number of passes over the array
	localparam int passes = opWidthX / rowsPerCycle;

	// Groups must tile the array exactly
	if (rowsPerCycle < 1 || passes * rowsPerCycle != opWidthX) begin : genGroupCheck
		$error("rowsPerCycle must divide opWidthX");
	end

	csPair_t accNext;

	////////////////////
	// Compressor chain
	////////////////////

	// One 3:2 level per row in the group
	always_comb begin : csaChain
		prod_t s;
		prod_t c;
		prod_t row;
		prod_t maj;
		int idx;
		s = acc.sum;
		c = acc.carry;
		for (int r = 0; r < rowsPerCycle; r++) begin
			// Row index of this level within the group
			idx = int'(pass) * rowsPerCycle + r;
			if (idx < opWidthX) begin
				row = pp[idx*prodWidth +: prodWidth];
			end else begin
				row = '0;
			end
			// Majority before sum overwrites s
			maj = (s & c) | (s & row) | (c & row);
			s = s ^ c ^ row;
			// Carries move one column up
			c = maj << 1;
		end
		accNext.sum = s;
		accNext.carry = c;
	end

	////////////////////
	// Pair register
	////////////////////

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			acc <= '0;
		end else if (accumulate) begin
			acc <= accNext;
		end
	end

	// Control never asks for a group past the last row
	assert property (@(posedge clk) disable iff (reset)
		accumulate |-> (int'(pass) < passes))
	else $error("Error: accumulate with pass 0x%0h beyond last group", pass);

endmodule

//--- PrefixAdder.sv
// Final carry-propagate adder
`timescale 1ns/1ps

module PrefixAdder #(
	parameter mulPkg::speed_e adderSpeed = mulPkg::MEDIUM
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            resolve,
	input  mulPkg::csPair_t acc,
	output mulPkg::prod_t   product
);
	import mulPkg::*;

	// Prefix depth for the parallel networks
	localparam int levels = log2floor(prodWidth);

	// Prefix trees below assume a power-of-two width
	if ((1 << levels) != prodWidth) begin : genWidthCheck
		$error("PrefixAdder needs a power-of-two product width");
	end

	prod_t genBits;
	prod_t propBits;
	prod_t carryIn;
	prod_t sumBits;

	// Bitwise generate and propagate
	assign genBits = acc.sum & acc.carry;
	assign propBits = acc.sum ^ acc.carry;

	////////////////////
	// Carry network
	////////////////////

	if (adderSpeed == SLOW) begin : genRipple
		// Linear chain, one cell per bit
		always_comb begin
			logic c;
			c = 1'b0;
			for (int i = 0; i < prodWidth; i++) begin
				carryIn[i] = c;
				c = genBits[i] | (propBits[i] & c);
			end
		end
	end else begin : genPrefix
		prod_t gLvl [levels+1];
		prod_t pLvl [levels+1];

		assign gLvl[0] = genBits;
		assign pLvl[0] = propBits;

		for (genvar l = 0; l < levels; l++) begin : genLevel
			for (genvar i = 0; i < prodWidth; i++) begin : genNode
				// Sklansky joins whole blocks, Kogge-Stone a fixed span back
				localparam bit active = (adderSpeed == FAST) ?
					(i >= (1 << l)) : (((i >> l) & 1) == 1);
				localparam int src = !active ? i : (adderSpeed == FAST) ?
					(i - (1 << l)) : (((i >> (l + 1)) << (l + 1)) + (1 << l) - 1);
				if (active) begin : genCell
					assign gLvl[l+1][i] = gLvl[l][i] | (pLvl[l][i] & gLvl[l][src]);
					assign pLvl[l+1][i] = pLvl[l][i] & pLvl[l][src];
				end else begin : genPass
					assign gLvl[l+1][i] = gLvl[l][i];
					assign pLvl[l+1][i] = pLvl[l][i];
				end
			end
		end

		// Group generate of bits below gives the carry in
		assign carryIn = {gLvl[levels][prodWidth-2:0], 1'b0};
	end

	assign sumBits = propBits ^ carryIn;

	////////////////////
	// Product register
	////////////////////

	// Held until the next resolve
	always_ff @(posedge clk) begin
		if (reset) begin
			product <= '0;
		end else if (resolve) begin
			product <= sumBits;
		end
	end

endmodule

//--- MulControl.sv
// Multiplier sequencing FSM
`timescale 1ns/1ps

module MulControl #(
	parameter int rowsPerCycle = 2
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	output logic             load,
	output logic             clear,
	output logic             accumulate,
	output mulPkg::passIdx_t pass,
	output logic             resolve,
	output logic             busy,
	output logic             done
);
	import mulPkg::*;

	// Passes per operation and bits to count them
	localparam int passes = opWidthX / rowsPerCycle;
	localparam int passBits = (passes > 1) ? log2floor(passes - 1) + 1 : 1;

	if (passBits > $bits(passIdx_t)) begin : genPassCheck
		$error("passIdx_t too narrow for the pass count");
	end

	typedef enum logic [1:0] {
		Idle,
		Accum,
		Resolve,
		Done
	} state_e;

	state_e state;
	logic startOk;
	logic lastPass;

	////////////////////
	// Strobes
	////////////////////

	// Start accepted whenever not busy, also in the done cycle
	assign startOk = start && (state == Idle || state == Done);
	assign load = startOk;
	assign clear = startOk;
	assign accumulate = (state == Accum);
	assign resolve = (state == Resolve);
	assign busy = accumulate || resolve;
	assign done = (state == Done);

	// Final group of the array
	assign lastPass = (pass[passBits-1:0] == passBits'(passes - 1));

	////////////////////
	// State and pass counter
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= Idle;
			pass <= '0;
		end else begin
			case (state)
				Idle, Done: begin
					pass <= '0;
					state <= startOk ? Accum : Idle;
				end
				Accum: begin
					if (lastPass) begin
						pass <= '0;
						state <= Resolve;
					end else begin
						pass <= pass + 1'b1;
					end
				end
				Resolve: state <= Done;
				default: state <= Idle;
			endcase
		end
	end

	// Single-cycle completion pulse
	assert property (@(posedge clk) disable iff (reset) done |=> !done)
	else $error("Error: done high for two cycles");

	// Adder resolves right after the final group
	assert property (@(posedge clk) disable iff (reset)
		(accumulate && lastPass) |=> (resolve && !accumulate))
	else $error("Error: resolve missing after last pass");

endmodule

//--- MulUnit.sv
// Iterative unsigned multiplier top
`timescale 1ns/1ps

module MulUnit #(
	parameter int             rowsPerCycle = 2,
	parameter mulPkg::speed_e adderSpeed   = mulPkg::MEDIUM
) (
	input  logic          clk,
	input  logic          reset,
	input  logic          start,
	input  mulPkg::opX_t  x,
	input  mulPkg::opY_t  y,
	output logic          busy,
	output logic          done,
	output mulPkg::prod_t product
);
	import mulPkg::*;

	// Latched operands
	opX_t xReg;
	opY_t yReg;

	// Control strobes
	logic load;
	logic clear;
	logic accumulate;
	logic resolve;
	passIdx_t pass;

	// Datapath nets
	ppArray_t ppRows;
	csPair_t accPair;

	////////////////////
	// Operand registers
	////////////////////

	// Stable for the whole operation
	always_ff @(posedge clk) begin
		if (load) begin
			xReg <= x;
			yReg <= y;
		end
	end

	////////////////////
	// Control and datapath
	////////////////////

	MulControl #(
		.rowsPerCycle(rowsPerCycle)
	) ctrl0 (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.load      (load),
		.clear     (clear),
		.accumulate(accumulate),
		.pass      (pass),
		.resolve   (resolve),
		.busy      (busy),
		.done      (done)
	);

	// Full array, combinational from the latched operands
	MulPPGenUns #(
		.widthX(opWidthX),
		.widthY(opWidthY)
	) ppGen0 (
		.X (xReg),
		.Y (yReg),
		.PP(ppRows)
	);

	CsaAccumulator #(
		.rowsPerCycle(rowsPerCycle)
	) csa0 (
		.clk       (clk),
		.reset     (reset),
		.clear     (clear),
		.accumulate(accumulate),
		.pass      (pass),
		.pp        (ppRows),
		.acc       (accPair)
	);

	PrefixAdder #(
		.adderSpeed(adderSpeed)
	) add0 (
		.clk    (clk),
		.reset  (reset),
		.resolve(resolve),
		.acc    (accPair),
		.product(product)
	);

endmodule

//--- tbMulUnit.sv
// Multiplier unit testbench
`timescale 1ns/1ps

module tbMulUnit;
	import mulPkg::*;

	// DUT configuration
	localparam int rowsPerCycle = 2;
	localparam speed_e adderSpeed = MEDIUM;

	// Row groups per operation
	localparam int passes = opWidthX / rowsPerCycle;
	// Done is seen this many edges after the start edge
	localparam int donePhase = passes + 2;
	// Generous bound for any single wait
	localparam int waitLimit = 4 * donePhase;

	logic clk;
	logic reset;
	logic start;
	opX_t x;
	opY_t y;
	logic busy;
	logic done;
	prod_t product;

	// Reference model state
	int phase;
	prod_t expProd;
	prod_t heldProd;

	int valueErrors;
	int timeoutErrors;
	int opsDone;
	int seedVal;

	MulUnit #(
		.rowsPerCycle(rowsPerCycle),
		.adderSpeed  (adderSpeed)
	) dut0 (
		.clk    (clk),
		.reset  (reset),
		.start  (start),
		.x      (x),
		.y      (y),
		.busy   (busy),
		.done   (done),
		.product(product)
	);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////
	// Reference model
	////////////////////

	// Phase counts edges since the accepted start, 0 when idle
	always @(posedge clk) begin
		if (reset) begin
			phase <= 0;
			expProd <= '0;
			heldProd <= '0;
			opsDone <= 0;
		end else begin
			if (phase == donePhase) begin
				heldProd <= expProd;
				opsDone <= opsDone + 1;
			end
			// Start only counts while the unit is not busy
			if (start && (phase == 0 || phase == donePhase)) begin
				phase <= 1;
				expProd <= prod_t'(x) * prod_t'(y);
			end else if (phase == donePhase) begin
				phase <= 0;
			end else if (phase != 0) begin
				phase <= phase + 1;
			end
		end
	end

	////////////////////
	// Checks
	////////////////////

	// Busy through the accumulate passes and the resolve cycle
	assert property (@(posedge clk) disable iff (reset)
		busy == (phase >= 1 && phase <= passes + 1))
	else begin
		valueErrors++;
		$display("Error: busy 0x%h, expected 0x%h", $sampled(busy),
			$sampled(phase >= 1 && phase <= passes + 1));
	end

	// Done only at the fixed latency
	assert property (@(posedge clk) disable iff (reset)
		done == (phase == donePhase))
	else begin
		valueErrors++;
		$display("Error: done 0x%h, expected 0x%h", $sampled(done),
			$sampled(phase == donePhase));
	end

	// One-cycle pulse
	assert property (@(posedge clk) disable iff (reset) done |=> !done)
	else begin
		valueErrors++;
		$display("Error: done 0x1 in consecutive cycles, expected 0x0");
	end

	// Result of the latched operands
	assert property (@(posedge clk) disable iff (reset)
		(phase == donePhase) |-> (product == expProd))
	else begin
		valueErrors++;
		$display("Error: product 0x%h, expected 0x%h", $sampled(product),
			$sampled(expProd));
	end

	// Zero before the first result, held afterwards
	assert property (@(posedge clk) disable iff (reset)
		(phase != donePhase) |-> (product == heldProd))
	else begin
		valueErrors++;
		$display("Error: product 0x%h, expected held 0x%h", $sampled(product),
			$sampled(heldProd));
	end

	////////////////////
	// Stimulus tasks
	////////////////////

	// All tasks start and end on a falling edge
	task automatic waitIdle(input int limit);
		int n;
		n = 0;
		while (busy && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			timeoutErrors++;
			$display("Timeout: busy stayed high for %0d cycles", limit);
		end
	endtask

	task automatic waitDone(input int limit);
		int n;
		n = 0;
		while (!done && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!done) begin
			timeoutErrors++;
			$display("Timeout: done did not rise within %0d cycles", limit);
		end
	endtask

	// One-cycle strobe, then scramble the operand inputs
	task automatic pulseStart(input opX_t a, input opY_t b);
		x = a;
		y = b;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		x = opX_t'($urandom());
		y = opY_t'($urandom());
	endtask

	// Next start comes in the cycle after done
	task automatic multiplyOnce(input opX_t a, input opY_t b);
		waitIdle(waitLimit);
		pulseStart(a, b);
		waitDone(waitLimit);
		@(negedge clk);
	endtask

	// Next start comes in the done cycle itself
	task automatic runBackToBack(input int count);
		int i;
		waitIdle(waitLimit);
		for (i = 0; i < count; i++) begin
			pulseStart(opX_t'($urandom()), opY_t'($urandom()));
			waitDone(waitLimit);
		end
		@(negedge clk);
	endtask

	// Strobes mid-run and in the resolve cycle must be ignored
	task automatic startWhileBusy(input opX_t a, input opY_t b);
		waitIdle(waitLimit);
		pulseStart(a, b);
		@(negedge clk);
		x = ~a;
		y = ~b;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// Move on to the resolve cycle
		repeat (passes - 2) @(negedge clk);
		x = opX_t'($urandom());
		y = opY_t'($urandom());
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		waitDone(waitLimit);
		@(negedge clk);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		int i;
		valueErrors = 0;
		timeoutErrors = 0;
		reset = 1'b1;
		start = 1'b0;
		x = '0;
		y = '0;
		seedVal = $urandom(32'h43f9_e756);

		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Idle a while, product must stay zero
		repeat (5) @(negedge clk);

		// Corner cases
		multiplyOnce(8'd0, 8'd173);
		multiplyOnce(8'd91, 8'd0);
		multiplyOnce(8'd1, 8'd200);
		multiplyOnce(8'd37, 8'd1);
		multiplyOnce(8'd255, 8'd255);
		multiplyOnce(8'd255, 8'd1);
		multiplyOnce(8'd128, 8'd2);

		// Random pairs
		for (i = 0; i < 40; i++) begin
			multiplyOnce(opX_t'($urandom()), opY_t'($urandom()));
		end

		// Ignored starts while busy
		startWhileBusy(8'd201, 8'd77);
		startWhileBusy(8'd255, 8'd255);
		startWhileBusy(opX_t'($urandom()), opY_t'($urandom()));

		runBackToBack(12);

		repeat (5) @(negedge clk);

		$display("Summary: %0d value errors, %0d timeouts, %0d operations checked",
			valueErrors, timeoutErrors, opsDone);
		if (valueErrors == 0 && timeoutErrors == 0 && opsDone > 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- sim.f
mulPkg.sv
MulPPGenUns.sv
CsaAccumulator.sv
PrefixAdder.sv
MulControl.sv
MulUnit.sv
tbMulUnit.sv

//--- Makefile
TOP = tbMulUnit

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
